/* design/gfx_pkg.sv */
// fill engine package with opcode and state enums and framebuffer geometry
`default_nettype none

package gfx_pkg;

  // framebuffer geometry
  localparam int SCREEN_W   = 16;               // pixels per row
  localparam int SCREEN_H   = 16;               // rows
  localparam int COORD_BITS = 8;                // x, y, w, h width

  // byte address of pixel (0,0)
  localparam logic [31:0] FB_BASE = 32'h0000_1000;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,                            // accepted, dropped
    OP_PIXEL = 2'd1,                            // single pixel write
    OP_RECT  = 2'd2,                            // rectangle fill
    OP_READ  = 2'd3                             // single pixel read
  } gfx_op_e;

  // rasterizer FSM
  typedef enum logic [1:0] {
    RS_IDLE = 2'd0,                             // waiting for a job
    RS_REQ  = 2'd1,                             // request up, cycle not yet open
    RS_WAIT = 2'd2                              // waiting for req_done
  } raster_state_e;

  // decoder job buffer
  typedef enum logic {
    DS_EMPTY = 1'b0,                            // ready for a command
    DS_FULL  = 1'b1                             // holding one clipped job
  } decode_state_e;

endpackage

`default_nettype wire

/* design/gfx_cmd_decoder.sv */
// command decoder that accepts host commands, clips them to the screen and buffers one job
`timescale 1ns/1ps
`default_nettype none

module gfx_cmd_decoder (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire                              cmd_valid_i,
  output logic                             cmd_ready_o,
  input  wire gfx_pkg::gfx_op_e            cmd_op_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_x_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_y_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_w_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_h_i,
  input  wire [31:0]                       cmd_color_i,
  output logic                             job_valid_o,
  output logic                             job_read_o,
  output logic [gfx_pkg::COORD_BITS-1:0]   job_x0_o,
  output logic [gfx_pkg::COORD_BITS-1:0]   job_y0_o,
  output logic [gfx_pkg::COORD_BITS-1:0]   job_x1_o,
  output logic [gfx_pkg::COORD_BITS-1:0]   job_y1_o,
  output logic [31:0]                      job_color_o,
  input  wire                              job_take_i
);

  import gfx_pkg::*;

  decode_state_e           state_q;             // one-entry buffer state
  logic                    is_unit;             // pixel or read opcode
  logic [COORD_BITS-1:0]   w_eff;               // width after opcode rule
  logic [COORD_BITS-1:0]   h_eff;               // height after opcode rule
  logic [COORD_BITS:0]     x_end;               // exclusive end, one extra bit
  logic [COORD_BITS:0]     y_end;
  logic [COORD_BITS-1:0]   x_clip;              // end bound clipped to screen
  logic [COORD_BITS-1:0]   y_clip;
  logic                    cmd_empty;           // nothing to draw or read
  logic                    cmd_fire;            // handshake this cycle

  assign cmd_ready_o = (state_q == DS_EMPTY);   // ready whenever buffer is free
  assign job_valid_o = (state_q == DS_FULL);
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  // pixel and read become 1x1 jobs
  assign is_unit = (cmd_op_i == OP_PIXEL) || (cmd_op_i == OP_READ);
  assign w_eff   = is_unit ? COORD_BITS'(1) : cmd_w_i;
  assign h_eff   = is_unit ? COORD_BITS'(1) : cmd_h_i;

  // end bounds, no wrap thanks to the extra bit
  assign x_end = {1'b0, cmd_x_i} + {1'b0, w_eff};
  assign y_end = {1'b0, cmd_y_i} + {1'b0, h_eff};

  // clip right and bottom edges
  assign x_clip = (x_end > SCREEN_W) ? COORD_BITS'(SCREEN_W) : x_end[COORD_BITS-1:0];
  assign y_clip = (y_end > SCREEN_H) ? COORD_BITS'(SCREEN_H) : y_end[COORD_BITS-1:0];

  // zero size, off-screen origin or nop
  assign cmd_empty = (cmd_op_i == OP_NOP)
                  || (w_eff == '0)
                  || (h_eff == '0)
                  || (cmd_x_i >= SCREEN_W)
                  || (cmd_y_i >= SCREEN_H);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= DS_EMPTY;                      // empty out of reset
    end
    else
    begin
      case (state_q)
        DS_EMPTY:
        begin
          if (cmd_fire && !cmd_empty)           // empty commands just vanish
            state_q <= DS_FULL;
        end
        DS_FULL:
        begin
          if (job_take_i)                       // rasterizer started the job
            state_q <= DS_EMPTY;
        end
        default: state_q <= DS_EMPTY;
      endcase
    end
  end

  // job fields, only meaningful while full
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      job_read_o  <= (cmd_op_i == OP_READ);
      job_x0_o    <= cmd_x_i;
      job_y0_o    <= cmd_y_i;
      job_x1_o    <= x_clip;
      job_y1_o    <= y_clip;
      job_color_o <= cmd_color_i;
    end
  end

endmodule

`default_nettype wire

/* design/gfx_rect_raster.sv */
// rectangle rasterizer that walks a clipped job and issues one memory request per pixel
`timescale 1ns/1ps
`default_nettype none

module gfx_rect_raster (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire                              job_valid_i,
  input  wire                              job_read_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    job_x0_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    job_y0_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    job_x1_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    job_y1_i,
  input  wire [31:0]                       job_color_i,
  output logic                             job_take_o,
  output logic                             req_rd_o,
  output logic                             req_wr_o,
  output logic [31:2]                      req_addr_o,
  output logic [31:0]                      req_dat_o,
  input  wire                              req_done_i,
  output logic                             busy_o
);

  import gfx_pkg::*;

  raster_state_e           state_q;
  logic                    read_q;              // job is a read
  logic [COORD_BITS-1:0]   x0_q;                // row restart column
  logic [COORD_BITS-1:0]   x1_q;                // exclusive right bound
  logic [COORD_BITS-1:0]   y1_q;                // exclusive bottom bound
  logic [31:0]             color_q;
  logic [COORD_BITS-1:0]   x_q;                 // current column
  logic [COORD_BITS-1:0]   y_q;                 // current row
  logic [31:2]             row_q;               // word address of (0, y_q)
  logic [31:2]             row_init;            // row address of first line
  logic                    x_last;              // last column of the row
  logic                    y_last;              // last row of the job
  logic                    active;

  // one multiply per job only, constant width so it folds to a shift
  assign row_init = FB_BASE[31:2] + 30'(job_y0_i) * 30'(SCREEN_W);

  assign x_last = (x_q + 1'b1) == x1_q;
  assign y_last = (y_q + 1'b1) == y1_q;

  assign active     = (state_q != RS_IDLE);
  assign busy_o     = active;
  assign job_take_o = (state_q == RS_IDLE) && job_valid_i;  // single-cycle take

  // level request held through RS_REQ and RS_WAIT
  assign req_rd_o   = active && read_q;
  assign req_wr_o   = active && !read_q;
  assign req_addr_o = row_q + 30'(x_q);         // row base plus column
  assign req_dat_o  = color_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= RS_IDLE;
      x_q     <= '0;
      y_q     <= '0;
      row_q   <= '0;
    end
    else
    begin
      case (state_q)
        RS_IDLE:
        begin
          if (job_valid_i)
          begin
            x_q     <= job_x0_i;                // start at top-left corner
            y_q     <= job_y0_i;
            row_q   <= row_init;
            state_q <= RS_REQ;                  // request on next cycle
          end
        end
        RS_REQ:
        begin
          state_q <= RS_WAIT;                   // bus master opens cycle now
        end
        RS_WAIT:
        begin
          if (req_done_i)
          begin
            if (x_last && y_last)
            begin
              state_q <= RS_IDLE;               // whole job done
            end
            else
            begin
              state_q <= RS_REQ;
              if (x_last)
              begin
                x_q   <= x0_q;                  // wrap to next row
                y_q   <= y_q + 1'b1;
                row_q <= row_q + 30'(SCREEN_W);
              end
              else
              begin
                x_q <= x_q + 1'b1;              // x steps fastest
              end
            end
          end
        end
        default: state_q <= RS_IDLE;
      endcase
    end
  end

  // job payload captured on take
  always_ff @(posedge clk_i)
  begin
    if (job_take_o)
    begin
      read_q  <= job_read_i;
      x0_q    <= job_x0_i;
      x1_q    <= job_x1_i;
      y1_q    <= job_y1_i;
      color_q <= job_color_i;
    end
  end

endmodule

`default_nettype wire

/* design/gfx_wbm_rw.sv */
// Wishbone classic master doing single reads and writes, with read result and error interrupt
`timescale 1ns/1ps
`default_nettype none

module gfx_wbm_rw (
  input  wire           clk_i,
  input  wire           rst_i,
  output logic          wb_cyc_o,
  output logic          wb_stb_o,
  output logic          wb_we_o,
  output logic [31:0]   wb_adr_o,
  output logic [3:0]    wb_sel_o,
  output logic [31:0]   wb_dat_o,
  input  wire           wb_ack_i,
  input  wire           wb_err_i,
  input  wire  [31:0]   wb_dat_i,
  input  wire           req_rd_i,
  input  wire           req_wr_i,
  input  wire  [31:2]   req_addr_i,
  input  wire  [31:0]   req_dat_i,
  output logic          req_done_o,
  output logic [31:0]   rd_dat_o,
  output logic          rd_valid_o,
  output logic          sint_o
);

  logic bus_end;                                // ack or err on open cycle
  logic start;                                  // open a new cycle

  assign bus_end = wb_cyc_o && (wb_ack_i || wb_err_i);
  assign start   = !wb_cyc_o && (req_rd_i || req_wr_i);

  assign wb_stb_o   = wb_cyc_o;                 // single access, strobe follows cycle
  assign wb_sel_o   = 4'b1111;                  // 32-bit accesses only
  assign req_done_o = bus_end;                  // pulse back to rasterizer

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_cyc_o   <= 1'b0;
      wb_we_o    <= 1'b0;
      rd_valid_o <= 1'b0;
      sint_o     <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        wb_cyc_o <= 1'b1;                       // edge after the request
        wb_we_o  <= req_wr_i;
      end
      else if (bus_end)
      begin
        wb_cyc_o <= 1'b0;                       // close on ack and on err
      end

      rd_valid_o <= bus_end && !wb_we_o;        // read result pulse

      if (wb_cyc_o && wb_err_i)
        sint_o <= 1'b1;                         // sticky until reset
    end
  end

  // address and data held for the whole cycle
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      wb_adr_o <= {req_addr_i, 2'b00};
      wb_dat_o <= req_dat_i;
    end
    if (bus_end && !wb_we_o)
      rd_dat_o <= wb_dat_i;                     // bus data even on err
  end

endmodule

`default_nettype wire

/* design/gfx_fill_top.sv */
// 2D fill engine top level joining decoder, rasterizer and Wishbone master
`timescale 1ns/1ps
`default_nettype none

module gfx_fill_top (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire                              cmd_valid_i,
  output logic                             cmd_ready_o,
  input  wire gfx_pkg::gfx_op_e            cmd_op_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_x_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_y_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_w_i,
  input  wire [gfx_pkg::COORD_BITS-1:0]    cmd_h_i,
  input  wire [31:0]                       cmd_color_i,
  output logic                             wb_cyc_o,
  output logic                             wb_stb_o,
  output logic                             wb_we_o,
  output logic [31:0]                      wb_adr_o,
  output logic [3:0]                       wb_sel_o,
  output logic [31:0]                      wb_dat_o,
  input  wire                              wb_ack_i,
  input  wire                              wb_err_i,
  input  wire [31:0]                       wb_dat_i,
  output logic [31:0]                      rd_dat_o,
  output logic                             rd_valid_o,
  output logic                             sint_o,
  output logic                             idle_o
);

  import gfx_pkg::*;

  // decoder to rasterizer
  logic                  job_valid;
  logic                  job_read;
  logic [COORD_BITS-1:0] job_x0;
  logic [COORD_BITS-1:0] job_y0;
  logic [COORD_BITS-1:0] job_x1;               // exclusive, clipped
  logic [COORD_BITS-1:0] job_y1;
  logic [31:0]           job_color;
  logic                  job_take;

  // rasterizer to bus master
  logic                  req_rd;
  logic                  req_wr;
  logic [31:2]           req_addr;              // word address
  logic [31:0]           req_dat;
  logic                  req_done;
  logic                  raster_busy;

  gfx_cmd_decoder u_dec (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_x_i     (cmd_x_i),
    .cmd_y_i     (cmd_y_i),
    .cmd_w_i     (cmd_w_i),
    .cmd_h_i     (cmd_h_i),
    .cmd_color_i (cmd_color_i),
    .job_valid_o (job_valid),
    .job_read_o  (job_read),
    .job_x0_o    (job_x0),
    .job_y0_o    (job_y0),
    .job_x1_o    (job_x1),
    .job_y1_o    (job_y1),
    .job_color_o (job_color),
    .job_take_i  (job_take)
  );

  gfx_rect_raster u_raster (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .job_valid_i (job_valid),
    .job_read_i  (job_read),
    .job_x0_i    (job_x0),
    .job_y0_i    (job_y0),
    .job_x1_i    (job_x1),
    .job_y1_i    (job_y1),
    .job_color_i (job_color),
    .job_take_o  (job_take),
    .req_rd_o    (req_rd),
    .req_wr_o    (req_wr),
    .req_addr_o  (req_addr),
    .req_dat_o   (req_dat),
    .req_done_i  (req_done),
    .busy_o      (raster_busy)
  );

  gfx_wbm_rw u_wbm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_sel_o    (wb_sel_o),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i),
    .wb_dat_i    (wb_dat_i),
    .req_rd_i    (req_rd),
    .req_wr_i    (req_wr),
    .req_addr_i  (req_addr),
    .req_dat_i   (req_dat),
    .req_done_o  (req_done),
    .rd_dat_o    (rd_dat_o),
    .rd_valid_o  (rd_valid_o),
    .sint_o      (sint_o)
  );

  // nothing buffered, nothing walking, no open cycle
  assign idle_o = !job_valid && !raster_busy && !wb_cyc_o;

endmodule

`default_nettype wire

/* test/gfx_tb_mem.sv */
// Wishbone slave memory for the testbench with random ack delay and one error word
`timescale 1ns/1ps
`default_nettype none

module gfx_tb_mem (
  input  wire          clk_i,
  input  wire          rst_i,
  input  wire          wb_cyc_i,
  input  wire          wb_stb_i,
  input  wire          wb_we_i,
  input  wire  [31:0]  wb_adr_i,
  input  wire  [3:0]   wb_sel_i,
  input  wire  [31:0]  wb_dat_i,
  output logic [31:0]  wb_dat_o,
  output logic         wb_ack_o,
  output logic         wb_err_o,
  input  wire          err_en_i,
  input  wire  [31:0]  err_adr_i
);

  import gfx_pkg::*;

  logic [31:0] mem [0:255];                     // one word per pixel
  logic [31:0] lfsr_q;
  logic [31:0] lfsr_mid;                        // state after the first bit
  logic [1:0]  wait_q;                          // wait states still to go
  logic [31:0] offset;
  logic [7:0]  idx;
  logic        bad;                             // outside memory or flagged
  logic        req;
  logic        fire;                            // respond on next edge

  // right-shift Galois form, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    fill_word = {8'hc3, a, ~a, a ^ 8'h5a};      // every index gives its own word
  endfunction

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(8'(i));
  end

  assign offset   = wb_adr_i - FB_BASE;
  assign idx      = offset[9:2];
  assign bad      = (offset[31:10] != '0) || (err_en_i && (wb_adr_i == err_adr_i));
  assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign fire     = req && (wait_q == 2'd0);
  assign lfsr_mid = lfsr_step(lfsr_q);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wait_q   <= 2'd0;
      lfsr_q   <= 32'hfc50;                     // fixed seed
    end
    else
    begin
      wb_ack_o <= fire && !bad;                 // single-cycle response
      wb_err_o <= fire && bad;
      if (fire)
      begin
        wait_q <= {lfsr_q[0], lfsr_mid[0]};     // next delay 0..3, two bits
        lfsr_q <= lfsr_step(lfsr_mid);
      end
      else if (req)
        wait_q <= wait_q - 2'd1;
    end
  end

  always @(posedge clk_i)
  begin
    if (fire)
    begin
      if (wb_we_i && !bad)
        for (int b = 0; b < 4; b++)
          if (wb_sel_i[b])
            mem[idx][8*b +: 8] = wb_dat_i[8*b +: 8];
      wb_dat_o <= mem[idx];                     // data returned on err too
    end
  end

endmodule

`default_nettype wire

/* test/gfx_tb.sv */
// testbench for the fill engine that replays a command file against a shadow framebuffer
`timescale 1ns/1ps
`default_nettype none

module gfx_tb;

  import gfx_pkg::*;

  localparam int WAIT_LIMIT = 5000;             // cycles allowed per wait loop

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  cmd_valid;
  logic                  cmd_ready;
  gfx_op_e               cmd_op;
  logic [COORD_BITS-1:0] cmd_x;
  logic [COORD_BITS-1:0] cmd_y;
  logic [COORD_BITS-1:0] cmd_w;
  logic [COORD_BITS-1:0] cmd_h;
  logic [31:0]           cmd_color;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [31:0]           wb_adr;
  logic [3:0]            wb_sel;
  logic [31:0]           wb_dat_w;
  logic                  wb_ack;
  logic                  wb_err;
  logic [31:0]           wb_dat_r;
  logic [31:0]           rd_dat;
  logic                  rd_valid;
  logic                  sint;
  logic                  idle;
  logic                  err_en;                // memory error word enable
  logic [31:0]           err_adr;

  logic [31:0] shadow [0:255];                  // expected framebuffer
  logic        sint_exp = 1'b0;
  logic        hung = 1'b0;                     // a wait loop ran out
  logic        cyc_prev = 1'b0;
  int          cyc_total = 0;                   // wb_cyc_o rising edges
  int          cyc_start;
  int          cyc_exp;
  int          errors = 0;
  int          err_start;
  int          checks = 0;
  int          tests_done = 0;
  int          cur_test = 0;

  always #50 clk = ~clk;                        // 100 ns period

  gfx_fill_top dut0 (
    .clk_i(clk), .rst_i(rst),
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_op_i(cmd_op),
    .cmd_x_i(cmd_x), .cmd_y_i(cmd_y), .cmd_w_i(cmd_w), .cmd_h_i(cmd_h),
    .cmd_color_i(cmd_color),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_dat_o(wb_dat_w), .wb_ack_i(wb_ack), .wb_err_i(wb_err),
    .wb_dat_i(wb_dat_r),
    .rd_dat_o(rd_dat), .rd_valid_o(rd_valid), .sint_o(sint), .idle_o(idle)
  );

  gfx_tb_mem mem0 (
    .clk_i(clk), .rst_i(rst),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err),
    .err_en_i(err_en), .err_adr_i(err_adr)
  );

  always @(posedge clk)
  begin
    if (wb_cyc && !cyc_prev)
      cyc_total <= cyc_total + 1;               // one per bus access
    cyc_prev <= wb_cyc;
    if (wb_stb !== wb_cyc)                      // single accesses only
    begin
      $display("error at %0t: wb_stb_o expected %b got %b", $time, wb_cyc, wb_stb);
      errors++;
    end
    if (wb_cyc && wb_sel !== 4'hf)              // always all four bytes
    begin
      $display("error at %0t: wb_sel_o expected f got %h", $time, wb_sel);
      errors++;
    end
  end

  function automatic logic [31:0] initial_pixel(input logic [7:0] a);
    initial_pixel = {8'hc3, a, ~a, a ^ 8'h5a};  // memory power-up content
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #1;                                         // drive and sample after the edge
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!idle && n < WAIT_LIMIT)
    begin
      step_cycle();
      n++;
    end
    if (!idle)
    begin
      $display("timeout at %0t: engine never returned to idle", $time);
      errors++;
      hung = 1'b1;
    end
  endtask

  task automatic wait_read();
    int n;
    n = 0;
    while (!rd_valid && n < WAIT_LIMIT)
    begin
      step_cycle();
      n++;
    end
    if (!rd_valid)
    begin
      $display("timeout at %0t: read result never came back", $time);
      errors++;
      hung = 1'b1;
    end
  endtask

  task automatic send_cmd(input int op, x, y, w, h, input logic [31:0] color);
    int n;
    cmd_valid = 1'b1;
    cmd_op    = gfx_op_e'(op[1:0]);
    cmd_x     = x[COORD_BITS-1:0];
    cmd_y     = y[COORD_BITS-1:0];
    cmd_w     = w[COORD_BITS-1:0];
    cmd_h     = h[COORD_BITS-1:0];
    cmd_color = color;
    n = 0;
    while (!cmd_ready && n < WAIT_LIMIT)       // back-pressure from full buffer
    begin
      step_cycle();
      n++;
    end
    if (!cmd_ready)
    begin
      $display("timeout at %0t: command was never accepted", $time);
      errors++;
      hung = 1'b1;
    end
    else
      step_cycle();                             // transfer edge
    cmd_valid = 1'b0;
  endtask

  // pixel and read count as 1x1 and the right and bottom edges stop at the screen
  task automatic shadow_update(input int op, x, y, w, h, input logic [31:0] color,
                               input int e);
    int ww;
    int hh;
    ww = (op == 1 || op == 3) ? 1 : w;
    hh = (op == 1 || op == 3) ? 1 : h;
    if (op != 0)
      for (int yy = y; yy < y + hh && yy < SCREEN_H; yy++)
        for (int xx = x; xx < x + ww && xx < SCREEN_W; xx++)
          if (e != 0 && xx == x && yy == y)
            sint_exp = 1'b1;                    // flagged word so the write is lost
          else if (op != 3)
            shadow[yy * SCREEN_W + xx] = color;
  endtask

  task automatic run_cmd(input int op, x, y, w, h, input logic [31:0] color,
                         input int e);
    if (e != 0)
    begin
      err_en  = 1'b1;
      err_adr = FB_BASE + 32'(4 * (y * SCREEN_W + x));  // origin word
    end
    send_cmd(op, x, y, w, h, color);
    shadow_update(op, x, y, w, h, color, e);
    if (op == 3 && x < SCREEN_W && y < SCREEN_H && !hung)
    begin
      wait_read();
      if (!hung)
      begin
        checks++;
        if (rd_dat !== shadow[y * SCREEN_W + x])
        begin
          $display("error at %0t: rd_dat_o expected %h got %h", $time,
                   shadow[y * SCREEN_W + x], rd_dat);
          errors++;
        end
      end
    end
  endtask

  task automatic begin_test(input int id);
    cur_test  = id;
    err_start = errors;
    cyc_start = cyc_total;
    cyc_exp   = 0;
  endtask

  task automatic end_test();
    if (cur_test > 0)
    begin
      if (!hung)
        wait_idle();
      if (!hung)
      begin
        checks++;
        if (cyc_total - cyc_start != cyc_exp)
        begin
          $display("error at %0t: wb_cyc_o rises expected %0d got %0d", $time,
                   cyc_exp, cyc_total - cyc_start);
          errors++;
        end
        checks++;
        if (sint !== sint_exp)                  // sticky once set
        begin
          $display("error at %0t: sint_o expected %b got %b", $time, sint_exp, sint);
          errors++;
        end
      end
      err_en = 1'b0;
      if (errors == err_start)
        $display("test %0d passed", cur_test);
      else
        $display("test %0d failed with %0d errors", cur_test, errors - err_start);
      tests_done++;
      cur_test = 0;
    end
  endtask

  initial
  begin
    int               fd;
    int               n;
    int               t;
    int               op;
    int               x;
    int               y;
    int               w;
    int               h;
    int               e;
    int               cyc;
    logic [31:0]      color;
    logic [8*128-1:0] line;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_x     = '0;
    cmd_y     = '0;
    cmd_w     = '0;
    cmd_h     = '0;
    cmd_color = '0;
    err_en    = 1'b0;
    err_adr   = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = initial_pixel(8'(i));
    repeat (8) step_cycle();                    // reset held 8 cycles
    rst = 1'b0;

    begin_test(1);                              // values straight out of reset
    checks += 6;
    if (cmd_ready !== 1'b1)
    begin
      $display("error at %0t: cmd_ready_o expected 1 got %b", $time, cmd_ready);
      errors++;
    end
    if (idle !== 1'b1)
    begin
      $display("error at %0t: idle_o expected 1 got %b", $time, idle);
      errors++;
    end
    if (wb_cyc !== 1'b0)
    begin
      $display("error at %0t: wb_cyc_o expected 0 got %b", $time, wb_cyc);
      errors++;
    end
    if (wb_stb !== 1'b0)
    begin
      $display("error at %0t: wb_stb_o expected 0 got %b", $time, wb_stb);
      errors++;
    end
    if (rd_valid !== 1'b0)
    begin
      $display("error at %0t: rd_valid_o expected 0 got %b", $time, rd_valid);
      errors++;
    end
    if (sint !== 1'b0)
    begin
      $display("error at %0t: sint_o expected 0 got %b", $time, sint);
      errors++;
    end
    end_test();

    fd = $fopen("test/gfx_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the command file test/gfx_testdata.txt");
      errors++;
    end
    else
    begin
      while (!hung && $fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%d %d %d %d %d %d %h %d %d", t, op, x, y, w, h, color, e, cyc);
        if (n == 9)                             // comment and blank lines skipped
        begin
          if (t != cur_test)
          begin
            end_test();
            begin_test(t);
          end
          run_cmd(op, x, y, w, h, color, e);
          cyc_exp += cyc;
        end
      end
      $fclose(fd);
      end_test();
    end

    $display("%0d tests run, %0d checks, %0d failed", tests_done, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* test/gfx_testdata.txt */
# test op x y w h colour err cycles, decimal except colour in hex
# op 0 nop, 1 pixel, 2 rect, 3 read; cycles is the expected bus accesses of the line
2  1   3   4   0   0  a1b2c3d4  0   1
2  3   3   4   0   0  00000000  0   1
3  1  11  14   0   0  0badf00d  0   1
3  2  12  13   8   6  11223344  0  12
3  3  12  13   0   0  00000000  0   1
3  3  15  15   0   0  00000000  0   1
3  3  14  14   0   0  00000000  0   1
3  3  11  13   0   0  00000000  0   1
3  3  12  12   0   0  00000000  0   1
3  3  11  14   0   0  00000000  0   1
4  2   2   2   0   3  deadbeef  0   0
4  2  16   3   4   4  deadbeef  0   0
4  2   5  20   2   2  deadbeef  0   0
4  0   1   1   4   4  deadbeef  0   0
4  2   6   6   3   0  deadbeef  0   0
4  1  17   0   0   0  deadbeef  0   0
4  3   3   4   0   0  00000000  0   1
5  2   0   0   5   3  55aa0001  0  15
5  2   3   1   4   4  55aa0002  0  16
5  1   2   2   0   0  55aa0003  0   1
5  2  10   8   9   2  55aa0004  0  12
5  2   0  15  16   1  55aa0005  0  16
5  3   4   2   0   0  00000000  0   1
5  3   2   2   0   0  00000000  0   1
5  3   0   0   0   0  00000000  0   1
5  3  15   9   0   0  00000000  0   1
5  3   9   8   0   0  00000000  0   1
5  3   7  15   0   0  00000000  0   1
6  2   4  10   3   2  77665544  1   6
6  3   4  10   0   0  00000000  0   1
6  3   5  10   0   0  00000000  0   1
6  3   6  11   0   0  00000000  0   1

/* verilog.f */
design/gfx_pkg.sv
design/gfx_cmd_decoder.sv
design/gfx_rect_raster.sv
design/gfx_wbm_rw.sv
design/gfx_fill_top.sv
test/gfx_tb_mem.sv
test/gfx_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
LINTFLAGS = --lint-only --timing
TOP       = gfx_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
